// ==== Bender.yml ====
package:
  name: fir_filter

sources:
  # Package first, then the RTL leaf blocks and the top level
  - hw/fir_pkg.sv
  - hw/fir_delay_line.sv
  - hw/fir_apb_regs.sv
  - hw/fir_mac.sv
  - hw/fir_top.sv
  - target: test
    files:
      - testbench/fir_top_sva.sv
      - testbench/tb_fir_top.sv

// ==== build.f ====
hw/fir_pkg.sv
hw/fir_delay_line.sv
hw/fir_apb_regs.sv
hw/fir_mac.sv
hw/fir_top.sv
testbench/fir_top_sva.sv
testbench/tb_fir_top.sv

// ==== hw/fir_apb_regs.sv ====
/*
 * FIR APB register block
 * Control register and tap coefficients, zero-wait-state slave
 * Generates a one-cycle clear pulse from the control register
 */

`timescale 1ns/1ps

module fir_apb_regs (
  input  logic                                      clk,
  input  logic                                      arst_n,
  // APB slave side
  input  fir_pkg::apb_addr_t                        paddr,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  fir_pkg::apb_data_t                        pwdata,
  output fir_pkg::apb_data_t                        prdata,
  // Filter control
  output logic                                      enable,
  output logic                                      clear,
  output fir_pkg::coef_t [fir_pkg::NUM_TAPS-1:0]    coef
);

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  logic                         access;
  logic                         wr_en;
  logic                         ctrl_sel;
  logic [fir_pkg::NUM_TAPS-1:0] coef_sel;

  // Access phase, the transfer always completes here
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  assign ctrl_sel = (paddr == fir_pkg::CTRL_ADDR);

  // One select per coefficient word
  for (genvar i = 0; i < fir_pkg::NUM_TAPS; i++) begin : gen_coef_dec
    assign coef_sel[i] = (paddr == fir_pkg::apb_addr_t'(fir_pkg::COEF_BASE_ADDR +
                                                        fir_pkg::COEF_STRIDE * i));
  end

  // ----------------------------------------
  // Control register
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
      clear  <= 1'b0;
    end else begin
      // Clear is not stored, it only lives for the cycle after the write
      clear <= wr_en & ctrl_sel & pwdata[1];
      if (wr_en && ctrl_sel) begin
        enable <= pwdata[0];
      end
    end
  end

  // ----------------------------------------
  // Coefficient registers
  // ----------------------------------------
  // Only the low COEF_W bits of the write data are kept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      coef <= '0;
    end else begin
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        if (wr_en && coef_sel[i]) begin
          coef[i] <= pwdata[fir_pkg::COEF_W-1:0];
        end
      end
    end
  end

  // ----------------------------------------
  // Read data
  // ----------------------------------------
  // Zero outside the access phase and for unmapped offsets
  always_comb begin
    prdata = '0;
    if (access) begin
      // Clear bit always reads back as 0
      if (ctrl_sel) begin
        prdata[0] = enable;
      end
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        if (coef_sel[i]) begin
          // Sign-extend to the bus width
          prdata = {{(fir_pkg::APB_DATA_W - fir_pkg::COEF_W){coef[i][fir_pkg::COEF_W-1]}},
                    coef[i]};
        end
      end
    end
  end

endmodule

// ==== hw/fir_delay_line.sv ====
/*
 * FIR delay line
 * Enabled shift register of samples, zeroed on reset or reinit
 */

`timescale 1ns/1ps

module fir_delay_line #(
  parameter int width      = 8,
  parameter int num_stages = 4
) (
  input  logic                                clk,
  input  logic                                arst_n,
  // Zeroes every stage at the next edge, wins over shift_en
  input  logic                                reinit,
  // Moves every stage one place older and loads shift_in into stage 0
  input  logic                                shift_en,
  input  logic [width-1:0]                    shift_in,
  // Stage 0 holds the newest sample
  output logic [num_stages-1:0][width-1:0]    taps
);

  // ----------------------------------------
  // Parameter checks
  // ----------------------------------------
  if (width < 1) begin : gen_width_check
    $error("fir_delay_line: width must be at least 1");
  end

  if (num_stages < 1) begin : gen_stages_check
    $error("fir_delay_line: num_stages must be at least 1");
  end

  // ----------------------------------------
  // Shift register
  // ----------------------------------------
  logic [num_stages-1:0][width-1:0] stages;
  logic [num_stages-1:0][width-1:0] stages_next;

  // A single stage just takes the new sample, there is nothing to shift
  if (num_stages == 1) begin : gen_one_stage
    assign stages_next = reinit ? '0 : shift_in;
  end else begin : gen_multi_stage
    // Oldest stage falls off the top
    assign stages_next = reinit ? '0 : {stages[num_stages-2:0], shift_in};
  end

  // Holds its contents unless shifting or reinitializing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stages <= '0;
    end else if (shift_en || reinit) begin
      stages <= stages_next;
    end
  end

  assign taps = stages;

endmodule

// ==== hw/fir_mac.sv ====
/*
 * FIR multiply-accumulate
 * Registered products, then a two-level adder tree into the result
 */

`timescale 1ns/1ps

module fir_mac (
  input  logic                                      clk,
  input  logic                                      arst_n,
  // High in the cycle before the edge that shifts the sample in
  input  logic                                      in_valid,
  // Drops everything in flight
  input  logic                                      clear,
  input  fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0]  taps,
  input  fir_pkg::coef_t [fir_pkg::NUM_TAPS-1:0]    coef,
  output logic                                      result_valid,
  output fir_pkg::acc_t                             result
);

  localparam int NUM_PAIRS = fir_pkg::NUM_TAPS / 2;

  // Tree pairs up taps in the first level
  if (fir_pkg::NUM_TAPS % 2 != 0) begin : gen_taps_check
    $error("fir_mac: NUM_TAPS must be even");
  end

  logic                                   tap_valid;
  logic                                   prod_valid;
  fir_pkg::prod_t [fir_pkg::NUM_TAPS-1:0] prod;
  fir_pkg::acc_t                          pair_sum [NUM_PAIRS];
  fir_pkg::acc_t                          sum;

  // ----------------------------------------
  // Valid pipeline
  // ----------------------------------------
  // tap_valid lines up with the taps after the accepting edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tap_valid    <= 1'b0;
      prod_valid   <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      tap_valid    <= in_valid;
      prod_valid   <= tap_valid & ~clear;
      result_valid <= prod_valid & ~clear;
    end
  end

  // ----------------------------------------
  // Stage 1, products
  // ----------------------------------------
  // Later coefficient writes no longer reach a registered product
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod <= '0;
    end else if (tap_valid) begin
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        prod[i] <= $signed(taps[i]) * $signed(coef[i]);
      end
    end
  end

  // ----------------------------------------
  // Stage 2, adder tree
  // ----------------------------------------
  always_comb begin
    // First level, neighbouring products sign-extended to full width
    for (int j = 0; j < NUM_PAIRS; j++) begin
      pair_sum[j] = fir_pkg::acc_t'($signed(prod[2*j])) +
                    fir_pkg::acc_t'($signed(prod[2*j+1]));
    end
    // Second level
    sum = '0;
    for (int j = 0; j < NUM_PAIRS; j++) begin
      sum = sum + pair_sum[j];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (prod_valid) begin
      result <= sum;
    end
  end

endmodule

// ==== hw/fir_pkg.sv ====
/*
 * FIR filter package
 * Widths, tap count, APB register map and the shared vector types
 */

package fir_pkg;

  // ----------------------------------------
  // Filter dimensions
  // ----------------------------------------
  // Number of taps, also the delay-line depth
  localparam int NUM_TAPS = 4;
  localparam int SAMPLE_W = 8;
  localparam int COEF_W   = 8;
  // Full product of a sample and a coefficient
  localparam int PROD_W   = 16;
  // Product width plus two guard bits for the four-way sum
  localparam int ACC_W    = 18;

  // ----------------------------------------
  // APB bus
  // ----------------------------------------
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic [APB_ADDR_W-1:0]      apb_addr_t;
  typedef logic [APB_DATA_W-1:0]      apb_data_t;

  // Control register, bit 0 enable, bit 1 clear (write-only)
  localparam apb_addr_t CTRL_ADDR = 8'h00;
  // Coefficient i lives at COEF_BASE_ADDR + COEF_STRIDE * i
  localparam apb_addr_t COEF_BASE_ADDR = 8'h10;
  localparam int COEF_STRIDE = 4;

endpackage

// ==== hw/fir_top.sv ====
/*
 * FIR filter top level
 * 4-tap FIR on a signed sample stream, coefficients set over APB
 */

`timescale 1ns/1ps

module fir_top (
  input  logic                clk,
  input  logic                arst_n,
  // APB slave
  input  fir_pkg::apb_addr_t  paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  fir_pkg::apb_data_t  pwdata,
  output fir_pkg::apb_data_t  prdata,
  // Sample stream, no back-pressure
  input  logic                sample_valid,
  input  fir_pkg::sample_t    sample_in,
  // Filtered stream, must be taken while result_valid is high
  output logic                result_valid,
  output fir_pkg::acc_t       result
);

  logic                                     enable;
  logic                                     clear;
  logic                                     accept;
  fir_pkg::coef_t [fir_pkg::NUM_TAPS-1:0]   coef;
  fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0] taps;

  // A sample offered during a clear is dropped
  assign accept = sample_valid & enable & ~clear;

  // ----------------------------------------
  // Register block
  // ----------------------------------------
  fir_apb_regs u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .enable  (enable),
    .clear   (clear),
    .coef    (coef)
  );

  // ----------------------------------------
  // Sample history
  // ----------------------------------------
  fir_delay_line #(
    .width      (fir_pkg::SAMPLE_W),
    .num_stages (fir_pkg::NUM_TAPS)
  ) u_delay_line (
    .clk      (clk),
    .arst_n   (arst_n),
    .reinit   (clear),
    .shift_en (accept),
    .shift_in (sample_in),
    .taps     (taps)
  );

  // ----------------------------------------
  // Multiply-accumulate
  // ----------------------------------------
  // Result comes out two edges after the accepting edge
  fir_mac u_mac (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (accept),
    .clear        (clear),
    .taps         (taps),
    .coef         (coef),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== testbench/fir_top_sva.sv ====
/*
 * FIR top-level checker
 * Result timing, reset state and clear behavior, bound into fir_top
 */

`timescale 1ns/1ps

module fir_top_sva (
  input logic                                     clk,
  input logic                                     arst_n,
  input logic                                     accept,
  input logic                                     enable,
  input logic                                     clear,
  input logic                                     result_valid,
  input fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0] taps
);

  // Failure count, watched by the testbench
  int fail_count = 0;

  // Result comes two edges after the accepting edge unless a clear hits it in flight
  a_result_timing: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid == ($past(accept, 3) && !$past(clear, 2) && !$past(clear, 1)))
  else begin
    fail_count++;
    $error("result_valid does not line up with an accepted sample");
  end

  // Nothing comes out and the filter stays off during reset
  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !result_valid && !enable)
  else begin
    fail_count++;
    $error("result_valid or enable high during reset");
  end

  // History is empty right after a clear pulse
  a_clear_zeroes: assert property (@(posedge clk) disable iff (!arst_n)
    clear |=> taps == '0)
  else begin
    fail_count++;
    $error("delay line taps not zero after clear");
  end

endmodule

bind fir_top fir_top_sva u_sva (
  .clk          (clk),
  .arst_n       (arst_n),
  .accept       (accept),
  .enable       (enable),
  .clear        (clear),
  .result_valid (result_valid),
  .taps         (taps)
);

// ==== testbench/tb_fir_top.sv ====
/*
 * FIR filter testbench
 * APB register access, random sample stream and a reference model
 * Results are checked against the model by assertions
 */

`timescale 1ns/1ps

module tb_fir_top;

  localparam int TIMEOUT_CYCLES = 50;

  logic               clk;
  logic               arst_n;
  fir_pkg::apb_addr_t paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  fir_pkg::apb_data_t pwdata;
  fir_pkg::apb_data_t prdata;
  logic               sample_valid;
  fir_pkg::sample_t   sample_in;
  logic               result_valid;
  fir_pkg::acc_t      result;

  // Expected read data, armed by the read task in the access phase
  logic               rd_check;
  fir_pkg::apb_data_t rd_expect;
  logic [31:0]        lfsr;

  // ----------------------------------------
  // Reference model state
  // ----------------------------------------
  fir_pkg::sample_t m_hist [fir_pkg::NUM_TAPS];
  fir_pkg::coef_t   m_coef [fir_pkg::NUM_TAPS];
  logic             m_enable;
  logic             m_clear;
  logic             m_p1_valid;
  logic             m_p2_valid;
  int               m_p1_val;
  int               m_p2_val;
  int               exp_q [$];
  int               exp_head;
  int               exp_count;

  fir_top DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .sample_valid (sample_valid),
    .sample_in    (sample_in),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 in right-shifting Galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      value = (value << 1) | lfsr[0];
    end
    return value;
  endfunction

  function automatic fir_pkg::apb_addr_t coef_addr(input int i);
    return fir_pkg::apb_addr_t'(fir_pkg::COEF_BASE_ADDR + fir_pkg::COEF_STRIDE * i);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  // ----------------------------------------
  // APB and sample drivers
  // ----------------------------------------
  task automatic apb_write(input fir_pkg::apb_addr_t addr, input fir_pkg::apb_data_t data);
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input fir_pkg::apb_addr_t addr, input fir_pkg::apb_data_t expected);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable   = 1'b1;
    rd_expect = expected;
    rd_check  = 1'b1;
    @(negedge clk);
    psel     = 1'b0;
    penable  = 1'b0;
    rd_check = 1'b0;
  endtask

  // Gaps drop sample_valid about one cycle in four
  task automatic drive_samples(input int count, input bit gaps);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      if (gaps) begin
        sample_valid = (rand_bits(2) != 0);
      end else begin
        sample_valid = 1'b1;
      end
      sample_in = fir_pkg::sample_t'(rand_bits(8));
    end
    @(negedge clk);
    sample_valid = 1'b0;
  endtask

  // Waits until every expected result has come out
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((exp_count != 0 || m_p1_valid || m_p2_valid) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_count != 0 || m_p1_valid || m_p2_valid) begin
      abort_run("timeout while waiting for the expected filter results");
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Mirrors the accept rule, the history and the two result stages
  always @(posedge clk or negedge arst_n) begin : ref_model
    int  sum;
    bit  acc;
    bit  wr;
    if (!arst_n) begin
      foreach (m_hist[i]) m_hist[i] = '0;
      foreach (m_coef[i]) m_coef[i] = '0;
      m_enable   = 1'b0;
      m_clear    = 1'b0;
      m_p1_valid = 1'b0;
      m_p2_valid = 1'b0;
      m_p1_val   = 0;
      m_p2_val   = 0;
      exp_q.delete();
      exp_head   = 0;
      exp_count  = 0;
    end else begin
      acc = sample_valid && m_enable && !m_clear;
      wr  = psel && penable && pwrite;
      // Result shown in the cycle that just ended is consumed
      if (result_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      // A clear drops both results in flight
      if (m_p2_valid && !m_clear) begin
        exp_q.push_back(m_p2_val);
      end
      m_p2_valid = m_p1_valid && !m_clear;
      m_p2_val   = m_p1_val;
      if (m_clear) begin
        foreach (m_hist[i]) m_hist[i] = '0;
      end else if (acc) begin
        for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--) begin
          m_hist[i] = m_hist[i-1];
        end
        m_hist[0] = sample_in;
      end
      // Register writes land on this edge
      m_clear = 1'b0;
      if (wr && paddr == fir_pkg::CTRL_ADDR) begin
        m_enable = pwdata[0];
        m_clear  = pwdata[1];
      end
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        if (wr && paddr == coef_addr(i)) begin
          m_coef[i] = pwdata[fir_pkg::COEF_W-1:0];
        end
      end
      // Filter rule on the history after the accepting edge
      m_p1_valid = acc;
      if (acc) begin
        sum = 0;
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
          sum = sum + int'(m_hist[i]) * int'(m_coef[i]);
        end
        m_p1_val = sum;
      end
      exp_head  = (exp_q.size() != 0) ? exp_q[0] : 0;
      exp_count = exp_q.size();
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_result_expected: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |-> exp_count != 0)
  else abort_run("result_valid high with no result expected");

  a_result_value: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && exp_count != 0 |-> int'(result) == exp_head)
  else abort_run($sformatf("mismatch at %0t: result expected %0d got %0d",
                           $time, $sampled(exp_head), $sampled(result)));

  a_prdata: assert property (@(posedge clk) disable iff (!arst_n)
    rd_check |-> prdata == rd_expect)
  else abort_run($sformatf("mismatch at %0t: prdata expected 0x%08h got 0x%08h",
                           $time, $sampled(rd_expect), $sampled(prdata)));

  // Bound checker failures end the run right away
  always @(posedge clk) begin
    if (DUT.u_sva.fail_count != 0) begin
      abort_run("a bound timing assertion on the DUT failed");
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    arst_n       = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    sample_valid = 1'b0;
    sample_in    = '0;
    rd_check     = 1'b0;
    rd_expect    = '0;
    lfsr         = 32'd68314;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    // Everything reads zero out of reset
    apb_read(fir_pkg::CTRL_ADDR, 32'h0);
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      apb_read(coef_addr(i), 32'h0);
    end

    // Sign extension, upper write bits dropped, clear reads 0, unmapped space
    apb_write(coef_addr(0), 32'h0000_0085);
    apb_write(coef_addr(1), 32'h1234_5617);
    apb_read(coef_addr(0), 32'hFFFF_FF85);
    apb_read(coef_addr(1), 32'h0000_0017);
    apb_write(fir_pkg::CTRL_ADDR, 32'h3);
    apb_read(fir_pkg::CTRL_ADDR, 32'h1);
    apb_write(8'h40, 32'hFFFF_FFFF);
    apb_read(8'h40, 32'h0);
    apb_read(8'h04, 32'h0);
    apb_read(8'h12, 32'h0);
    apb_read(coef_addr(0), 32'hFFFF_FF85);

    // Random taps, a gappy stream, then back to back
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      apb_write(coef_addr(i), rand_bits(8));
    end
    drive_samples(40, 1'b1);
    drive_samples(12, 1'b0);
    wait_idle();

    // Disabled filter ignores the stream and keeps its history
    apb_write(fir_pkg::CTRL_ADDR, 32'h0);
    drive_samples(8, 1'b1);
    wait_idle();
    apb_write(fir_pkg::CTRL_ADDR, 32'h1);
    drive_samples(4, 1'b0);
    wait_idle();

    // Clear with samples in flight and one offered in the clear cycle
    @(negedge clk);
    sample_valid = 1'b1;
    sample_in    = fir_pkg::sample_t'(rand_bits(8));
    apb_write(fir_pkg::CTRL_ADDR, 32'h3);
    drive_samples(6, 1'b0);
    wait_idle();

    // Coefficient write lands one edge after the first sample is taken,
    // while its result is still in flight, so only the second sample sees it
    fork
      drive_samples(1, 1'b0);
      apb_write(coef_addr(2), 32'h0000_007F);
    join
    drive_samples(1, 1'b0);
    wait_idle();

    if (DUT.u_sva.fail_count != 0) begin
      abort_run("a bound timing assertion on the DUT failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule
